/* alien_formation.f */
alien_pkg.sv
alien_motion.sv
alien_hit_decode.sv
alien_sprite_rom.sv
alien_formation.sv
alien_formation_sva.sv
tb_alien_formation.sv

/* alien_formation.sv */
// Alien formation top level
// Moving row of five sprites, decoded per pixel through a
// two-stage pipeline into colour and slot mask
`timescale 1ns/1ps
`default_nettype none

module alien_formation #(
    parameter int                MOVE_PERIOD  = 16000000,
    parameter alien_pkg::coord_t START_ROW    = 12'd20,
    parameter alien_pkg::coord_t START_COLUMN = 12'd246
) (
    input  logic                  clk,
    input  logic                  rst,
    input  alien_pkg::coord_t     pixel_row,
    input  alien_pkg::coord_t     pixel_column,
    output alien_pkg::color_t     alien_color,
    output alien_pkg::slot_mask_t alien_active,
    output alien_pkg::coord_t     formation_row,
    output alien_pkg::coord_t     formation_column
);

    import alien_pkg::*;

    slot_mask_t hit_mask;
    local_t     local_row;
    local_t     local_col;

    alien_motion #(
        .MOVE_PERIOD  (MOVE_PERIOD),
        .START_ROW    (START_ROW),
        .START_COLUMN (START_COLUMN)
    ) u_motion (
        .clk              (clk),
        .rst              (rst),
        .formation_row    (formation_row),
        .formation_column (formation_column)
    );

    // Stage 1 uses the position current when the pixel is sampled
    alien_hit_decode u_hit_decode (
        .clk              (clk),
        .rst              (rst),
        .pixel_row        (pixel_row),
        .pixel_column     (pixel_column),
        .formation_row    (formation_row),
        .formation_column (formation_column),
        .hit_mask         (hit_mask),
        .local_row        (local_row),
        .local_col        (local_col)
    );

    alien_sprite_rom u_sprite_rom (
        .clk          (clk),
        .rst          (rst),
        .hit_mask     (hit_mask),
        .local_row    (local_row),
        .local_col    (local_col),
        .alien_color  (alien_color),
        .alien_active (alien_active)
    );

endmodule

`default_nettype wire

/* alien_formation_sva.sv */
// Alien formation bound checker
// Output consistency and legal formation moves
`timescale 1ns/1ps
`default_nettype none

module alien_formation_sva (
    input logic                  clk,
    input logic                  rst,
    input alien_pkg::color_t     alien_color,
    input alien_pkg::slot_mask_t alien_active,
    input alien_pkg::coord_t     formation_row,
    input alien_pkg::coord_t     formation_column
);

    import alien_pkg::*;

    // Slot boxes never overlap
    active_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(alien_active)
    ) else $error("alien_active has more than one slot set: %b", alien_active);

    color_needs_slot: assert property (
        @(posedge clk) disable iff (rst) (alien_color != '0) |-> (alien_active != '0)
    ) else $error("alien_color %0d with no active slot", alien_color);

    // A move is one sideways step or one drop, never both
    property legal_move;
        @(posedge clk) disable iff (rst)
        (formation_row != $past(formation_row)
            || formation_column != $past(formation_column))
        |-> ((formation_row == $past(formation_row)
                && (formation_column == $past(formation_column) + STEP_COLUMNS
                    || formation_column == $past(formation_column) - STEP_COLUMNS))
            || (formation_column == $past(formation_column)
                && formation_row == $past(formation_row) + DROP_ROWS));
    endproperty

    move_step_or_drop: assert property (legal_move)
        else $error("illegal move to row %0d column %0d", formation_row, formation_column);

endmodule

bind alien_formation alien_formation_sva u_sva (
    .clk              (clk),
    .rst              (rst),
    .alien_color      (alien_color),
    .alien_active     (alien_active),
    .formation_row    (formation_row),
    .formation_column (formation_column)
);

`default_nettype wire

/* alien_hit_decode.sv */
// Alien slot decode, first pipeline stage
// Finds which slot box covers the pixel and the local sprite
// coordinates inside that slot
`timescale 1ns/1ps
`default_nettype none

module alien_hit_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  alien_pkg::coord_t     pixel_row,
    input  alien_pkg::coord_t     pixel_column,
    input  alien_pkg::coord_t     formation_row,
    input  alien_pkg::coord_t     formation_column,
    output alien_pkg::slot_mask_t hit_mask,
    output alien_pkg::local_t     local_row,
    output alien_pkg::local_t     local_col
);

    import alien_pkg::*;

    // Box covers origin+1 .. origin+16
    localparam coord_t BOX_END = coord_t'(SPRITE_SIZE + 1);

    coord_t     slot_col [ALIEN_COUNT];
    coord_t     row_off;
    coord_t     col_off;
    logic       in_rows;
    slot_mask_t hit_next;
    local_t     local_col_next;

    assign in_rows = (pixel_row > formation_row) && (pixel_row < formation_row + BOX_END);
    assign row_off = pixel_row - formation_row - 12'd1;

    always_comb
    begin
        hit_next       = '0;
        col_off        = '0;
        local_col_next = '0;
        for (int k = 0; k < ALIEN_COUNT; k++)
        begin
            slot_col[k] = formation_column + coord_t'(ALIEN_PITCH * k);
            hit_next[k] = in_rows && (pixel_column > slot_col[k])
                          && (pixel_column < slot_col[k] + BOX_END);
            // Slots never overlap, so at most one origin is picked
            if (hit_next[k])
            begin
                col_off        = pixel_column - slot_col[k] - 12'd1;
                local_col_next = col_off[3:0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hit_mask  <= '0;
            local_row <= '0;
            local_col <= '0;
        end
        else
        begin
            hit_mask  <= hit_next;
            local_row <= in_rows ? row_off[3:0] : '0;
            local_col <= local_col_next;
        end
    end

endmodule

`default_nettype wire

/* alien_motion.sv */
// Alien formation motion
// Counts the move period and steps the formation sideways,
// dropping and reversing at the screen limits
`timescale 1ns/1ps
`default_nettype none

module alien_motion #(
    parameter int                MOVE_PERIOD  = 16000000,
    parameter alien_pkg::coord_t START_ROW    = 12'd20,
    parameter alien_pkg::coord_t START_COLUMN = 12'd246
) (
    input  logic              clk,
    input  logic              rst,
    output alien_pkg::coord_t formation_row,
    output alien_pkg::coord_t formation_column
);

    import alien_pkg::*;

    localparam int CNT_W = (MOVE_PERIOD > 1) ? $clog2(MOVE_PERIOD) : 1;

    logic [CNT_W-1:0] move_count;
    logic             move_wrap;
    dir_t             dir;
    dir_t             dir_next;
    coord_t           row_next;
    coord_t           col_next;

    assign move_wrap = (move_count == CNT_W'(MOVE_PERIOD - 1));

    // Next position and direction, applied only on a period wrap
    always_comb
    begin
        row_next = formation_row;
        col_next = formation_column;
        dir_next = dir;
        case (dir)
            DIR_RIGHT:
            begin
                if (formation_column > RIGHT_LIMIT)
                begin
                    row_next = formation_row + DROP_ROWS;
                    dir_next = DIR_LEFT;
                end
                else
                begin
                    col_next = formation_column + STEP_COLUMNS;
                end
            end
            DIR_LEFT:
            begin
                if (formation_column < LEFT_LIMIT)
                begin
                    row_next = formation_row + DROP_ROWS;
                    dir_next = DIR_RIGHT;
                end
                else
                begin
                    col_next = formation_column - STEP_COLUMNS;
                end
            end
            default:
            begin
                dir_next = DIR_RIGHT;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            move_count       <= '0;
            formation_row    <= START_ROW;
            formation_column <= START_COLUMN;
            dir              <= DIR_RIGHT;
        end
        else if (move_wrap)
        begin
            move_count       <= '0;
            formation_row    <= row_next;
            formation_column <= col_next;
            dir              <= dir_next;
        end
        else
        begin
            move_count <= move_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* alien_pkg.sv */
// Alien formation shared definitions
// Coordinate and colour types, formation geometry, motion limits
// and the 16x16 sprite bitmap
`default_nettype none

package alien_pkg;

    localparam int ALIEN_COUNT = 5;
    localparam int SPRITE_SIZE = 16;
    localparam int ALIEN_PITCH = 32;

    typedef logic [11:0]            coord_t;
    typedef logic [3:0]             color_t;
    typedef logic [3:0]             local_t;
    typedef logic [ALIEN_COUNT-1:0] slot_mask_t;
    typedef logic [15:0]            bitmap_row_t;

    typedef enum logic {
        DIR_RIGHT = 1'b0,
        DIR_LEFT  = 1'b1
    } dir_t;

    localparam color_t ALIEN_COLOR  = 4'd15;

    // Motion constants
    localparam coord_t STEP_COLUMNS = 12'd12;
    localparam coord_t DROP_ROWS    = 12'd24;
    localparam coord_t LEFT_LIMIT   = 12'd21;
    localparam coord_t RIGHT_LIMIT  = 12'd500;

    // Sprite shape, bit i is local column i
    // Rows come in identical pairs
    localparam bitmap_row_t ALIEN_BITMAP [SPRITE_SIZE] = '{
        16'h03C0, 16'h03C0,
        16'h0FF0, 16'h0FF0,
        16'h3FFC, 16'h3FFC,
        16'hF3CF, 16'hF3CF,
        16'hFFFF, 16'hFFFF,
        16'h0C30, 16'h0C30,
        16'h33CC, 16'h33CC,
        16'hCC33, 16'hCC33
    };

endpackage

`default_nettype wire

/* alien_sprite_rom.sv */
// Alien sprite lookup, second pipeline stage
// Reads the bitmap at the local coordinates and registers the
// pixel colour with the slot mask
`timescale 1ns/1ps
`default_nettype none

module alien_sprite_rom (
    input  logic                  clk,
    input  logic                  rst,
    input  alien_pkg::slot_mask_t hit_mask,
    input  alien_pkg::local_t     local_row,
    input  alien_pkg::local_t     local_col,
    output alien_pkg::color_t     alien_color,
    output alien_pkg::slot_mask_t alien_active
);

    import alien_pkg::*;

    bitmap_row_t row_bits;
    logic        pixel_lit;

    assign row_bits  = ALIEN_BITMAP[local_row];
    assign pixel_lit = row_bits[local_col] && (|hit_mask);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            alien_color  <= '0;
            alien_active <= '0;
        end
        else
        begin
            alien_color  <= pixel_lit ? ALIEN_COLOR : '0;
            alien_active <= hit_mask;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the alien formation testbench with Verilator
# The verdict comes from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_alien_formation

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_alien_formation -f alien_formation.f \
    -Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Compile failed with status $status"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation stopped with status $status"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

/* tb_alien_formation.sv */
// Alien formation testbench
// Random pixels, half of them aimed at the formation box, checked
// against a reference model of motion and sprite lookup
`timescale 1ns/1ps
`default_nettype none

module tb_alien_formation;

    import alien_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int MOVE_PERIOD  = 64;
    localparam int RESET_CYCLES = 16;
    // Past the right turn, the left turn and one step after it
    localparam int RUN_CYCLES      = 70 * MOVE_PERIOD;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RUN_CYCLES + 1000;
    localparam int LIT_COLOR       = 15;

    logic       clk;
    logic       rst;
    coord_t     pixel_row;
    coord_t     pixel_column;
    color_t     alien_color;
    slot_mask_t alien_active;
    coord_t     formation_row;
    coord_t     formation_column;

    integer     seed;
    int         model_row;
    int         model_col;
    int         model_count;
    logic       model_right;
    int         right_turns;
    int         left_turns;
    logic       after_reset;
    logic [4:0] lit_slots;
    logic [4:0] mask_q [$];
    logic [3:0] color_q [$];
    logic [4:0] new_mask;
    logic [3:0] new_color;
    logic [4:0] due_mask;
    logic [3:0] due_color;

    alien_formation #(
        .MOVE_PERIOD (MOVE_PERIOD)
    ) uut (
        .clk              (clk),
        .rst              (rst),
        .pixel_row        (pixel_row),
        .pixel_column     (pixel_column),
        .alien_color      (alien_color),
        .alien_active     (alien_active),
        .formation_row    (formation_row),
        .formation_column (formation_column)
    );

    always #4 clk = ~clk;

    task automatic fail_value(input string name, input int expected, input int actual);
        $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Sprite shape, looked up by row pair
    function automatic logic sprite_lit(input int lr, input int lc);
        case (lr / 2)
            0: return lc inside {[6:9]};
            1: return lc inside {[4:11]};
            2: return lc inside {[2:13]};
            3: return lc inside {[0:3], [6:9], [12:15]};
            4: return 1'b1;
            5: return lc inside {4, 5, 10, 11};
            6: return lc inside {2, 3, [6:9], 12, 13};
            default: return lc inside {0, 1, 4, 5, 10, 11, 14, 15};
        endcase
    endfunction

    task automatic compute_expected(input int pr, input int pc,
                                    output logic [4:0] mask, output logic [3:0] color);
        int org;
        mask  = '0;
        color = '0;
        if (pr > model_row && pr < model_row + 17)
        begin
            for (int k = 0; k < 5; k++)
            begin
                org = model_col + 32 * k;
                if (pc > org && pc < org + 17)
                begin
                    mask[k] = 1'b1;
                    if (sprite_lit(pr - model_row - 1, pc - org - 1))
                        color = 4'(LIT_COLOR);
                end
            end
        end
    endtask

    task automatic advance_model();
        if (model_count == MOVE_PERIOD - 1)
        begin
            model_count = 0;
            if (model_right && model_col > 500)
            begin
                model_row   = model_row + 24;
                model_right = 1'b0;
                right_turns++;
            end
            else if (!model_right && model_col < 21)
            begin
                model_row   = model_row + 24;
                model_right = 1'b1;
                left_turns++;
            end
            else if (model_right)
                model_col = model_col + 12;
            else
                model_col = model_col - 12;
        end
        else
            model_count++;
    endtask

    // Half the draws land in or just around the formation box
    task automatic drive_pixel();
        int r;
        int c;
        if (($random(seed) & 1) == 0)
        begin
            r = model_row + ($random(seed) & 32'h7fff_ffff) % 18;
            c = model_col + ($random(seed) & 32'h7fff_ffff) % 146;
        end
        else
        begin
            r = ($random(seed) & 32'h7fff_ffff) % 480;
            c = ($random(seed) & 32'h7fff_ffff) % 640;
        end
        pixel_row    <= coord_t'(r);
        pixel_column <= coord_t'(c);
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            model_row   = 20;
            model_col   = 246;
            model_count = 0;
            model_right = 1'b1;
            after_reset = 1'b1;
            mask_q.delete();
            color_q.delete();
        end
        else
        begin
            if (after_reset)
            begin
                assert (alien_active == '0)
                    else fail_value("alien_active", 0, int'(alien_active));
                assert (alien_color == '0)
                    else fail_value("alien_color", 0, int'(alien_color));
                assert (formation_row == 12'd20)
                    else fail_value("formation_row", 20, int'(formation_row));
                assert (formation_column == 12'd246)
                    else fail_value("formation_column", 246, int'(formation_column));
                after_reset = 1'b0;
            end
            assert (int'(formation_row) == model_row)
                else fail_value("formation_row", model_row, int'(formation_row));
            assert (int'(formation_column) == model_col)
                else fail_value("formation_column", model_col, int'(formation_column));
            // Result of the pixel sampled two edges ago
            if (mask_q.size() == 2)
            begin
                due_mask  = mask_q.pop_front();
                due_color = color_q.pop_front();
                assert (alien_active == due_mask)
                    else fail_value("alien_active", int'(due_mask), int'(alien_active));
                assert (alien_color == due_color)
                    else fail_value("alien_color", int'(due_color), int'(alien_color));
                if (due_color != '0)
                    lit_slots = lit_slots | due_mask;
            end
            compute_expected(int'(pixel_row), int'(pixel_column), new_mask, new_color);
            mask_q.push_back(new_mask);
            color_q.push_back(new_color);
            advance_model();
            drive_pixel();
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $fatal(1);
    end

    initial
    begin
        seed         = 32'h74b2_0e42;
        clk          = 1'b0;
        rst          = 1'b1;
        // Lit pixel of slot 0 at the start position, held through reset
        pixel_row    = 12'd28;
        pixel_column = 12'd254;
        right_turns  = 0;
        left_turns   = 0;
        lit_slots    = '0;
        after_reset  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (RUN_CYCLES) @(posedge clk);
        @(negedge clk);
        // Both turn points and a lit pixel in every slot
        if (right_turns == 0 || left_turns == 0 || lit_slots != 5'h1f)
        begin
            $display("Stimulus missed a case: right turns %0d, left turns %0d, lit slots %b",
                     right_turns, left_turns, lit_slots);
            $display("Verification failed");
            $fatal(1);
        end
        else
        begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
